/* rtl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;
	typedef logic [4:0]  rd_tag_t;
	typedef logic [2:0]  axsize_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	typedef enum logic [1:0] {
		OP_NONE,
		OP_LOAD,
		OP_STORE
	} mem_op_t;

	// encoding matches the AXI size code
	typedef enum logic [1:0] {
		SZ_BYTE,
		SZ_HALF,
		SZ_WORD
	} mem_size_t;

	typedef enum logic [3:0] {
		S_IDLE,
		S_LOCK,
		S_READ_ADDR,
		S_READ_DATA,
		S_WRITE_ADDR,
		S_WRITE_RESP,
		S_DELAY,
		S_ACCESS
	} lsu_state_t;

endpackage

`default_nettype wire

/* rtl/store_align.sv */
`timescale 1ns/100ps
`default_nettype none

module store_align (
	input  lsu_pkg::addr_t    addr,
	input  lsu_pkg::mem_size_t size,
	input  lsu_pkg::word_t    data,
	output lsu_pkg::word_t    wdata,
	output lsu_pkg::strb_t    wstrb,
	output lsu_pkg::axsize_t  awsize
);

	// move the low lanes up to the addressed byte
	assign wdata = data << {addr[1:0], 3'b000};

	assign awsize = lsu_pkg::axsize_t'({1'b0, size});

	always_comb begin
		wstrb = 4'b0000;
		case (size)
			lsu_pkg::SZ_BYTE: begin
				wstrb = 4'b0001 << addr[1:0];
			end
			lsu_pkg::SZ_HALF: begin
				// only halfword-aligned offsets write anything
				if (addr[1:0] == 2'b00) begin
					wstrb = 4'b0011;
				end else if (addr[1:0] == 2'b10) begin
					wstrb = 4'b1100;
				end
			end
			lsu_pkg::SZ_WORD: begin
				if (addr[1:0] == 2'b00) begin
					wstrb = 4'b1111;
				end
			end
			default: begin
				wstrb = 4'b0000;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/load_extend.sv */
`timescale 1ns/100ps
`default_nettype none

module load_extend (
	input  lsu_pkg::addr_t     addr,
	input  lsu_pkg::mem_size_t size,
	input  logic               is_unsigned,
	input  lsu_pkg::word_t     rdata,
	output lsu_pkg::word_t     result
);

	lsu_pkg::word_t shifted;

	// addressed byte or half lands in the low lanes
	assign shifted = rdata >> {addr[1:0], 3'b000};

	always_comb begin
		case (size)
			lsu_pkg::SZ_BYTE: begin
				if (is_unsigned) begin
					result = {24'b0, shifted[7:0]};
				end else begin
					result = {{24{shifted[7]}}, shifted[7:0]};
				end
			end
			lsu_pkg::SZ_HALF: begin
				if (is_unsigned) begin
					result = {16'b0, shifted[15:0]};
				end else begin
					result = {{16{shifted[15]}}, shifted[15:0]};
				end
			end
			default: begin
				// word load, no shift applied
				result = rdata;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/mem_access_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_access_fsm (
	input  logic               clk,
	input  logic               reset,
	// upstream
	input  logic               in_valid,
	output logic               in_ready,
	input  lsu_pkg::mem_op_t   in_op,
	input  lsu_pkg::mem_size_t in_size,
	input  logic               in_unsigned,
	input  lsu_pkg::addr_t     in_addr,
	input  lsu_pkg::word_t     in_wdata,
	input  lsu_pkg::rd_tag_t   in_rd,
	// writeback
	output logic               out_valid,
	input  logic               out_ready,
	output lsu_pkg::word_t     out_rdata,
	output lsu_pkg::rd_tag_t   out_rd,
	output logic               out_err,
	// read channels
	output logic               arvalid,
	input  logic               arready,
	output lsu_pkg::addr_t     araddr,
	output lsu_pkg::axsize_t   arsize,
	input  logic               rvalid,
	output logic               rready,
	input  lsu_pkg::resp_t     rresp,
	// write channels
	output logic               awvalid,
	input  logic               awready,
	output lsu_pkg::addr_t     awaddr,
	output logic               wvalid,
	input  logic               wready,
	input  logic               bvalid,
	output logic               bready,
	input  lsu_pkg::resp_t     bresp,
	// alignment blocks
	input  lsu_pkg::word_t     load_result,
	output lsu_pkg::addr_t     lock_addr,
	output lsu_pkg::mem_size_t lock_size,
	output logic               lock_unsigned,
	output lsu_pkg::word_t     lock_wdata
);

	lsu_pkg::lsu_state_t state;
	lsu_pkg::mem_op_t    lock_op;

	// address held stable for the whole transaction
	assign araddr = lock_addr;
	assign awaddr = lock_addr;
	assign arsize = lsu_pkg::axsize_t'({1'b0, lock_size});

	// latched operation fields
	always_ff @(posedge clk) begin
		if (state == lsu_pkg::S_IDLE && in_valid && in_ready) begin
			lock_op       <= in_op;
			lock_addr     <= in_addr;
			lock_size     <= in_size;
			lock_unsigned <= in_unsigned;
			lock_wdata    <= in_wdata;
			out_rd        <= in_rd;
		end
	end

	// result and error, cleared on acceptance for the no-access case
	always_ff @(posedge clk) begin
		if (state == lsu_pkg::S_IDLE && in_valid && in_ready) begin
			out_rdata <= '0;
			out_err   <= 1'b0;
		end else if (state == lsu_pkg::S_READ_DATA && rvalid) begin
			out_rdata <= load_result;
			out_err   <= (rresp != lsu_pkg::RESP_OKAY);
		end else if (state == lsu_pkg::S_WRITE_RESP && bvalid) begin
			out_err   <= (bresp != lsu_pkg::RESP_OKAY);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= lsu_pkg::S_IDLE;
			in_ready  <= 1'b1;
			out_valid <= 1'b0;
			arvalid   <= 1'b0;
			rready    <= 1'b0;
			awvalid   <= 1'b0;
			wvalid    <= 1'b0;
			bready    <= 1'b0;
		end else begin
			case (state)
				lsu_pkg::S_IDLE: begin
					if (in_valid && in_ready) begin
						in_ready <= 1'b0;
						state    <= lsu_pkg::S_LOCK;
					end
				end
				lsu_pkg::S_LOCK: begin
					if (lock_op == lsu_pkg::OP_LOAD) begin
						arvalid <= 1'b1;
						state   <= lsu_pkg::S_READ_ADDR;
					end else if (lock_op == lsu_pkg::OP_STORE) begin
						// address and data go out together
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
						state   <= lsu_pkg::S_WRITE_ADDR;
					end else begin
						state   <= lsu_pkg::S_DELAY;
					end
				end
				lsu_pkg::S_READ_ADDR: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= lsu_pkg::S_READ_DATA;
					end
				end
				lsu_pkg::S_READ_DATA: begin
					if (rvalid) begin
						rready <= 1'b0;
						state  <= lsu_pkg::S_DELAY;
					end
				end
				lsu_pkg::S_WRITE_ADDR: begin
					// memory accepts both channels in the same cycle
					if (awready && wready) begin
						awvalid <= 1'b0;
						wvalid  <= 1'b0;
						bready  <= 1'b1;
						state   <= lsu_pkg::S_WRITE_RESP;
					end
				end
				lsu_pkg::S_WRITE_RESP: begin
					if (bvalid) begin
						bready <= 1'b0;
						state  <= lsu_pkg::S_DELAY;
					end
				end
				lsu_pkg::S_DELAY: begin
					out_valid <= 1'b1;
					state     <= lsu_pkg::S_ACCESS;
				end
				lsu_pkg::S_ACCESS: begin
					// hold the result until writeback takes it
					if (out_ready) begin
						out_valid <= 1'b0;
						in_ready  <= 1'b1;
						state     <= lsu_pkg::S_IDLE;
					end
				end
				default: begin
					state <= lsu_pkg::S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/axi_lite_sram.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_lite_sram #(
	parameter int MEM_WORDS = 1024
) (
	input  logic             clk,
	input  logic             reset,
	// read channels
	input  logic             arvalid,
	output logic             arready,
	input  lsu_pkg::addr_t   araddr,
	input  lsu_pkg::axsize_t arsize,
	output logic             rvalid,
	input  logic             rready,
	output lsu_pkg::word_t   rdata,
	output lsu_pkg::resp_t   rresp,
	// write channels
	input  logic             awvalid,
	output logic             awready,
	input  lsu_pkg::addr_t   awaddr,
	input  lsu_pkg::axsize_t awsize,
	input  logic             wvalid,
	output logic             wready,
	input  lsu_pkg::word_t   wdata,
	input  lsu_pkg::strb_t   wstrb,
	output logic             bvalid,
	input  logic             bready,
	output lsu_pkg::resp_t   bresp
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam lsu_pkg::addr_t WORDS_LIMIT = lsu_pkg::addr_t'(MEM_WORDS);

	lsu_pkg::word_t mem [MEM_WORDS];

	logic rd_ok;
	logic wr_ok;
	logic ar_fire;
	logic w_fire;

	// word index in range and no access wider than the bus
	assign rd_ok = ({2'b00, araddr[31:2]} < WORDS_LIMIT) && (arsize <= 3'd2);
	assign wr_ok = ({2'b00, awaddr[31:2]} < WORDS_LIMIT) && (awsize <= 3'd2);

	// one read and one write outstanding at most
	assign arready = !rvalid;
	assign awready = awvalid && wvalid && !bvalid;
	assign wready  = awready;

	assign ar_fire = arvalid && arready;
	assign w_fire  = awready;

	always_ff @(posedge clk) begin
		if (reset) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (ar_fire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			if (w_fire) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// read data and response, zero data on a range error
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rdata <= rd_ok ? mem[araddr[2 +: IDX_W]] : '0;
			rresp <= rd_ok ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
		end
	end

	always_ff @(posedge clk) begin
		if (w_fire) begin
			bresp <= wr_ok ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
			for (int b = 0; b < 4; b++) begin
				if (wr_ok && wstrb[b]) begin
					mem[awaddr[2 +: IDX_W]][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
	parameter int MEM_WORDS = 1024
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               in_valid,
	output logic               in_ready,
	input  lsu_pkg::mem_op_t   in_op,
	input  lsu_pkg::mem_size_t in_size,
	input  logic               in_unsigned,
	input  lsu_pkg::addr_t     in_addr,
	input  lsu_pkg::word_t     in_wdata,
	input  lsu_pkg::rd_tag_t   in_rd,
	output logic               out_valid,
	input  logic               out_ready,
	output lsu_pkg::word_t     out_rdata,
	output lsu_pkg::rd_tag_t   out_rd,
	output logic               out_err
);

	logic               arvalid, arready, rvalid, rready;
	logic               awvalid, awready, wvalid, wready, bvalid, bready;
	lsu_pkg::addr_t     araddr, awaddr, lock_addr;
	lsu_pkg::axsize_t   arsize, awsize;
	lsu_pkg::word_t     rdata, wdata_aligned, load_result, lock_wdata;
	lsu_pkg::strb_t     wstrb;
	lsu_pkg::resp_t     rresp, bresp;
	lsu_pkg::mem_size_t lock_size;
	logic               lock_unsigned;

	mem_access_fsm mem_access_fsm_inst (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .in_op(in_op), .in_size(in_size),
		.in_unsigned(in_unsigned), .in_addr(in_addr), .in_wdata(in_wdata), .in_rd(in_rd),
		.out_valid(out_valid), .out_ready(out_ready), .out_rdata(out_rdata),
		.out_rd(out_rd), .out_err(out_err),
		.arvalid(arvalid), .arready(arready), .araddr(araddr), .arsize(arsize),
		.rvalid(rvalid), .rready(rready), .rresp(rresp),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready), .bresp(bresp),
		.load_result(load_result), .lock_addr(lock_addr), .lock_size(lock_size),
		.lock_unsigned(lock_unsigned), .lock_wdata(lock_wdata)
	);

	store_align store_align_inst (
		.addr(lock_addr), .size(lock_size), .data(lock_wdata),
		.wdata(wdata_aligned), .wstrb(wstrb), .awsize(awsize)
	);

	load_extend load_extend_inst (
		.addr(lock_addr), .size(lock_size), .is_unsigned(lock_unsigned),
		.rdata(rdata), .result(load_result)
	);

	axi_lite_sram #(.MEM_WORDS(MEM_WORDS)) axi_lite_sram_inst (
		.clk(clk), .reset(reset),
		.arvalid(arvalid), .arready(arready), .araddr(araddr), .arsize(arsize),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awsize(awsize),
		.wvalid(wvalid), .wready(wready), .wdata(wdata_aligned), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp)
	);

endmodule

`default_nettype wire

/* test/tb_lsu.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lsu;

	localparam int WAIT_LIMIT = 50;

	logic               clk;
	logic               reset;
	logic               in_valid;
	logic               in_ready;
	lsu_pkg::mem_op_t   in_op;
	lsu_pkg::mem_size_t in_size;
	logic               in_unsigned;
	lsu_pkg::addr_t     in_addr;
	lsu_pkg::word_t     in_wdata;
	lsu_pkg::rd_tag_t   in_rd;
	logic               out_valid;
	logic               out_ready;
	lsu_pkg::word_t     out_rdata;
	lsu_pkg::rd_tag_t   out_rd;
	logic               out_err;

	int error_count;
	int mem_words;
	int latency;

	// expected memory contents keyed by word index
	lsu_pkg::word_t ref_mem [int];

	lsu_top lsu_top_inst (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .in_op(in_op), .in_size(in_size),
		.in_unsigned(in_unsigned), .in_addr(in_addr), .in_wdata(in_wdata), .in_rd(in_rd),
		.out_valid(out_valid), .out_ready(out_ready), .out_rdata(out_rdata),
		.out_rd(out_rd), .out_err(out_err)
	);

	always #2 clk = ~clk;

	task automatic finish_run;
		$display("closing summary: %0d error(s)", error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("TIMEOUT at %0t: waited %0d cycles for %s", $time, WAIT_LIMIT, what);
		error_count++;
		finish_run();
	endtask

	task automatic check_value(input string name, input lsu_pkg::word_t expected,
		input lsu_pkg::word_t actual);
		assert (actual == expected) else begin
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// misaligned half and word stores write no bytes
	function automatic void ref_store(input lsu_pkg::addr_t addr,
		input lsu_pkg::mem_size_t size, input lsu_pkg::word_t data);
		int idx;
		int off;
		int nbytes;
		lsu_pkg::word_t w;
		idx = int'(addr[31:2]);
		off = int'(addr[1:0]);
		nbytes = (size == lsu_pkg::SZ_BYTE) ? 1 : (size == lsu_pkg::SZ_HALF) ? 2 : 4;
		if (idx >= mem_words || off % nbytes != 0) begin
			return;
		end
		w = ref_mem[idx];
		for (int b = 0; b < nbytes; b++) begin
			w[8*(off+b) +: 8] = data[8*b +: 8];
		end
		ref_mem[idx] = w;
	endfunction

	function automatic lsu_pkg::word_t ref_load(input lsu_pkg::addr_t addr,
		input lsu_pkg::mem_size_t size, input logic uns);
		lsu_pkg::word_t w;
		int off;
		logic [7:0] part_b;
		logic [15:0] part_h;
		if (int'(addr[31:2]) >= mem_words) begin
			return '0;
		end
		w = ref_mem[int'(addr[31:2])];
		off = int'(addr[1:0]);
		case (size)
			lsu_pkg::SZ_BYTE: begin
				part_b = w[8*off +: 8];
				return uns ? {24'b0, part_b} : {{24{part_b[7]}}, part_b};
			end
			lsu_pkg::SZ_HALF: begin
				part_h = w[8*off +: 16];
				return uns ? {16'b0, part_h} : {{16{part_h[15]}}, part_h};
			end
			default: begin
				return w;
			end
		endcase
	endfunction

	// returns right after the accepting edge
	task automatic do_op(input lsu_pkg::mem_op_t op, input lsu_pkg::mem_size_t size,
		input logic uns, input lsu_pkg::addr_t addr, input lsu_pkg::word_t data,
		input lsu_pkg::rd_tag_t rd);
		int waited;
		waited = 0;
		@(posedge clk);
		in_valid    <= 1'b1;
		in_op       <= op;
		in_size     <= size;
		in_unsigned <= uns;
		in_addr     <= addr;
		in_wdata    <= data;
		in_rd       <= rd;
		do begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("in_ready to accept an operation");
			end
		end while (!in_ready);
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic get_result(input lsu_pkg::word_t exp_data, input lsu_pkg::rd_tag_t exp_rd,
		input logic exp_err, input int stall);
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("out_valid with a result");
			end
		end while (!out_valid);
		// first negedge already follows the accepting edge
		latency = waited - 1;
		check_value("out_rdata", exp_data, out_rdata);
		check_value("out_rd", lsu_pkg::word_t'(exp_rd), lsu_pkg::word_t'(out_rd));
		check_value("out_err", lsu_pkg::word_t'(exp_err), lsu_pkg::word_t'(out_err));
		repeat (stall) begin
			@(negedge clk);
			check_value("out_valid", 32'd1, lsu_pkg::word_t'(out_valid));
			check_value("in_ready", 32'd0, lsu_pkg::word_t'(in_ready));
			check_value("out_rdata", exp_data, out_rdata);
			check_value("out_rd", lsu_pkg::word_t'(exp_rd), lsu_pkg::word_t'(out_rd));
			check_value("out_err", lsu_pkg::word_t'(exp_err), lsu_pkg::word_t'(out_err));
		end
		@(posedge clk);
		out_ready <= 1'b1;
		@(posedge clk);
		out_ready <= 1'b0;
		// result taken once and not offered again
		@(negedge clk);
		check_value("out_valid", 32'd0, lsu_pkg::word_t'(out_valid));
		check_value("in_ready", 32'd1, lsu_pkg::word_t'(in_ready));
	endtask

	task automatic run_op(input lsu_pkg::mem_op_t op, input lsu_pkg::mem_size_t size,
		input logic uns, input lsu_pkg::addr_t addr, input lsu_pkg::word_t data,
		input lsu_pkg::rd_tag_t rd, input int stall);
		lsu_pkg::word_t exp_data;
		logic exp_err;
		exp_err = (op != lsu_pkg::OP_NONE) && (int'(addr[31:2]) >= mem_words);
		exp_data = '0;
		if (op == lsu_pkg::OP_LOAD) begin
			exp_data = ref_load(addr, size, uns);
		end
		do_op(op, size, uns, addr, data, rd);
		get_result(exp_data, rd, exp_err, stall);
		if (op == lsu_pkg::OP_STORE) begin
			ref_store(addr, size, data);
		end
	endtask

	function automatic lsu_pkg::addr_t rand_word_addr();
		return lsu_pkg::addr_t'($urandom_range(mem_words - 1, 0)) << 2;
	endfunction

	function automatic lsu_pkg::rd_tag_t rand_tag();
		return lsu_pkg::rd_tag_t'($urandom());
	endfunction

	task automatic word_roundtrip_test;
		lsu_pkg::addr_t a;
		repeat (8) begin
			a = rand_word_addr();
			run_op(lsu_pkg::OP_STORE, lsu_pkg::SZ_WORD, 1'b0, a, $urandom(), rand_tag(), 0);
			run_op(lsu_pkg::OP_LOAD, lsu_pkg::SZ_WORD, 1'b0, a, '0, rand_tag(), 0);
		end
	endtask

	// odd half and unaligned word offsets must leave memory unchanged
	task automatic partial_store_test;
		lsu_pkg::addr_t a;
		a = rand_word_addr();
		run_op(lsu_pkg::OP_STORE, lsu_pkg::SZ_WORD, 1'b0, a, $urandom(), rand_tag(), 0);
		for (int sz = 0; sz < 3; sz++) begin
			for (int off = 0; off < 4; off++) begin
				run_op(lsu_pkg::OP_STORE, lsu_pkg::mem_size_t'(sz), 1'b0, a | lsu_pkg::addr_t'(off),
					$urandom(), rand_tag(), 0);
				run_op(lsu_pkg::OP_LOAD, lsu_pkg::SZ_WORD, 1'b0, a, '0, rand_tag(), 0);
			end
		end
	endtask

	task automatic load_extend_test;
		lsu_pkg::addr_t a;
		lsu_pkg::word_t pattern;
		for (int n = 0; n < 2; n++) begin
			a = rand_word_addr();
			pattern = $urandom();
			// sign bit of every byte set on the first pass
			if (n == 0) begin
				pattern = pattern | 32'h8080_8080;
			end
			run_op(lsu_pkg::OP_STORE, lsu_pkg::SZ_WORD, 1'b0, a, pattern, rand_tag(), 0);
			for (int uns = 0; uns < 2; uns++) begin
				for (int off = 0; off < 4; off++) begin
					run_op(lsu_pkg::OP_LOAD, lsu_pkg::SZ_BYTE, 1'(uns), a | lsu_pkg::addr_t'(off),
						'0, rand_tag(), 0);
				end
				for (int off = 0; off < 4; off += 2) begin
					run_op(lsu_pkg::OP_LOAD, lsu_pkg::SZ_HALF, 1'(uns), a | lsu_pkg::addr_t'(off),
						'0, rand_tag(), 0);
				end
			end
		end
	endtask

	task automatic no_access_test;
		repeat (3) begin
			run_op(lsu_pkg::OP_NONE, lsu_pkg::SZ_WORD, 1'b0, $urandom(), $urandom(), rand_tag(), 0);
			check_value("out_valid delay", 32'd2, lsu_pkg::word_t'(latency));
		end
	endtask

	task automatic range_error_test;
		lsu_pkg::addr_t last;
		lsu_pkg::addr_t beyond;
		last = lsu_pkg::addr_t'((mem_words - 1) * 4);
		beyond = lsu_pkg::addr_t'(mem_words * 4);
		run_op(lsu_pkg::OP_STORE, lsu_pkg::SZ_WORD, 1'b0, '0, $urandom(), rand_tag(), 0);
		run_op(lsu_pkg::OP_STORE, lsu_pkg::SZ_WORD, 1'b0, last, $urandom(), rand_tag(), 0);
		// index 0 aliases the first word past the end
		run_op(lsu_pkg::OP_STORE, lsu_pkg::SZ_WORD, 1'b0, beyond, $urandom(), rand_tag(), 0);
		run_op(lsu_pkg::OP_STORE, lsu_pkg::SZ_BYTE, 1'b0, 32'hFFFF_FFFD, $urandom(), rand_tag(), 0);
		run_op(lsu_pkg::OP_LOAD, lsu_pkg::SZ_WORD, 1'b0, beyond, '0, rand_tag(), 0);
		run_op(lsu_pkg::OP_LOAD, lsu_pkg::SZ_HALF, 1'b0, 32'hFFFF_FFFE, '0, rand_tag(), 0);
		run_op(lsu_pkg::OP_LOAD, lsu_pkg::SZ_WORD, 1'b0, '0, '0, rand_tag(), 0);
		run_op(lsu_pkg::OP_LOAD, lsu_pkg::SZ_WORD, 1'b0, last, '0, rand_tag(), 0);
	endtask

	task automatic backpressure_test;
		int base;
		int off;
		int stall;
		lsu_pkg::mem_op_t op;
		lsu_pkg::mem_size_t size;
		base = $urandom_range(mem_words - 8, 0);
		for (int k = 0; k < 8; k++) begin
			run_op(lsu_pkg::OP_STORE, lsu_pkg::SZ_WORD, 1'b0, lsu_pkg::addr_t'((base + k) * 4),
				$urandom(), rand_tag(), 0);
		end
		for (int i = 0; i < 200; i++) begin
			op = lsu_pkg::mem_op_t'($urandom_range(2, 0));
			size = lsu_pkg::mem_size_t'($urandom_range(2, 0));
			off = $urandom_range(3, 0);
			if (op == lsu_pkg::OP_LOAD) begin
				off = (size == lsu_pkg::SZ_WORD) ? 0 : (size == lsu_pkg::SZ_HALF) ? off & 2 : off;
			end
			stall = ($urandom_range(1, 0) == 1) ? $urandom_range(6, 1) : 0;
			run_op(op, size, 1'($urandom_range(1, 0)),
				lsu_pkg::addr_t'((base + $urandom_range(7, 0)) * 4 + off), $urandom(),
				lsu_pkg::rd_tag_t'(i), stall);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = lsu_pkg::OP_NONE;
		in_size = lsu_pkg::SZ_BYTE;
		in_unsigned = 1'b0;
		in_addr = '0;
		in_wdata = '0;
		in_rd = '0;
		out_ready = 1'b0;
		error_count = 0;
		latency = 0;
		mem_words = lsu_top_inst.MEM_WORDS;
		void'($urandom(53983));
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		word_roundtrip_test();
		partial_store_test();
		load_extend_test();
		no_access_test();
		range_error_test();
		backpressure_test();
		finish_run();
	end

endmodule

`default_nettype wire

/* project.f */
rtl/lsu_pkg.sv
rtl/store_align.sv
rtl/load_extend.sv
rtl/mem_access_fsm.sv
rtl/axi_lite_sram.sv
rtl/lsu_top.sv
test/tb_lsu.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/100ps -f project.f \
		--top-module tb_lsu -Mdir obj_dir -o sim
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
